// File: Makefile
# Verilator build and run for the calc back end

VERILATOR ?= verilator
TOP       ?= calc_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
common/calc_pkg.sv
hdl/calc_decode.sv
hdl/calc_operand.sv
hdl/calc_execute.sv
hdl/calc_complete.sv
hdl/calc_top.sv
dv/calc_clk_gen.sv
dv/calc_assertions.sv
dv/calc_tb.sv

// File: common/calc_pkg.sv
// ============================================================
// Calc back end shared package
// Data path widths, register file size, pipeline depths,
// opcode encoding and the common word types
// ============================================================

package calc_pkg;

  // Data path and register file
  localparam int DATA_W     = 32;
  localparam int REG_NUM    = 16;
  localparam int REG_ADDR_W = 4;

  // Completion stages between reservation and writeback
  localparam int COMP_STAGES = 3;

  // Three completion stage inputs plus writeback
  localparam int FWD_DEPTH = 4;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Integer opcodes, shifts take rs2[4:0]
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SLL  = 4'd6,
    OP_SRL  = 4'd7,
    OP_ADDI = 4'd8,
    OP_MUL  = 4'd9
  } calc_op_e;

endpackage

// File: dv/calc_assertions.sv
// ============================================================
// Calc writeback assertions
// Writeback quiet in reset and after flush, never to x0
// ============================================================
`timescale 1ns/1ps

module calc_assertions (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                flush_i,
  input logic                wb_v_i,
  input calc_pkg::reg_addr_t wb_addr_i
);

  a_reset_quiet : assert property (@(posedge clk_i) !arst_n_i |-> !wb_v_i)
    else $error("writeback strobe high during reset");

  // Four cycles of silence follow each sampled flush
  a_flush_quiet : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ($past(flush_i, 1) || $past(flush_i, 2) || $past(flush_i, 3) || $past(flush_i, 4))
    |-> !wb_v_i)
    else $error("writeback strobe high within four cycles of a flush");

  a_no_x0_write : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_v_i |-> (wb_addr_i != '0))
    else $error("writeback to register 0");

endmodule

bind calc_top calc_assertions u_calc_assertions (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .flush_i   (flush_i),
  .wb_v_i    (wb_v_o),
  .wb_addr_i (wb_addr_o)
);

// File: dv/calc_clk_gen.sv
// ============================================================
// Calc testbench clock and reset
// Free-running clock and an active-low reset pulse
// ============================================================
`timescale 1ns/1ps

module calc_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial
  begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: dv/calc_tb.sv
// ============================================================
// Calc back end testbench
// Directed and random instruction streams checked against
// an in-order register model with flush roll-back
// ============================================================
`timescale 1ns/1ps

module calc_tb;

  import calc_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int RAND_INSTR  = 300;
  localparam int NUM_DISPATCH = RAND_INSTR + 100;

  logic      clk;
  logic      arst_n;
  logic      dispatch_v;
  calc_op_e  op;
  reg_addr_t rd_addr;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  data_t     imm;
  logic      flush;
  logic      wb_v;
  reg_addr_t wb_addr;
  data_t     wb_data;

  int        seed = 84;
  int        errors = 0;
  int        cyc = 0;
  data_t     arch [REG_NUM];
  // Dispatches still open to a flush
  int        pend_cyc [$];
  reg_addr_t pend_addr [$];
  data_t     pend_data [$];
  reg_addr_t exp_addr_q [$];
  data_t     exp_data_q [$];
  reg_addr_t exp_addr;
  data_t     exp_data;

  calc_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  calc_top u_calc_top (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .dispatch_v_i (dispatch_v),
    .op_i         (op),
    .rd_addr_i    (rd_addr),
    .rs1_addr_i   (rs1_addr),
    .rs2_addr_i   (rs2_addr),
    .imm_i        (imm),
    .flush_i      (flush),
    .wb_v_o       (wb_v),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data)
  );

  function automatic data_t calc_ref(input calc_op_e op_v, input data_t a, input data_t b,
                                     input data_t im);
    data_t r;
    case (op_v)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SLL:  r = a << b[4:0];
      OP_SRL:  r = a >> b[4:0];
      OP_ADDI: r = a + im;
      OP_MUL:  r = a * b;
      default: r = '0;
    endcase
    return r;
  endfunction

  // Program-order value, youngest open write wins
  function automatic data_t model_read(input reg_addr_t a);
    data_t v;
    v = (a == '0) ? '0 : arch[a];
    for (int i = 0; i < pend_addr.size(); i++)
      if (pend_addr[i] == a && a != '0)
        v = pend_data[i];
    return v;
  endfunction

  task automatic drive_slot(input logic v, input calc_op_e o, input reg_addr_t rd,
                            input reg_addr_t rs1, input reg_addr_t rs2, input data_t im,
                            input logic fl);
    data_t res;
    @(negedge clk);
    res = calc_ref(o, model_read(rs1), model_read(rs2), im);
    dispatch_v = v;
    op         = v ? o : OP_NOP;
    rd_addr    = rd;
    rs1_addr   = rs1;
    rs2_addr   = rs2;
    imm        = im;
    flush      = fl;
    if (v && o != OP_NOP && rd != '0)
    begin
      pend_cyc.push_back(cyc);
      pend_addr.push_back(rd);
      pend_data.push_back(res);
    end
    // Flush kills this slot and the three before it
    if (fl)
    begin
      pend_cyc.delete();
      pend_addr.delete();
      pend_data.delete();
    end
    while (pend_cyc.size() > 0 && pend_cyc[0] <= cyc - 3)
    begin
      void'(pend_cyc.pop_front());
      arch[pend_addr[0]] = pend_data[0];
      exp_addr_q.push_back(pend_addr.pop_front());
      exp_data_q.push_back(pend_data.pop_front());
    end
    cyc++;
  endtask

  task automatic issue(input calc_op_e o, input reg_addr_t rd, input reg_addr_t rs1,
                       input reg_addr_t rs2, input data_t im);
    drive_slot(1'b1, o, rd, rs1, rs2, im, 1'b0);
  endtask

  task automatic run_random(input int count);
    logic [31:0] rnd;
    logic [3:0]  opv;
    logic        prev_mul;
    reg_addr_t   prev_rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    prev_mul = 1'b0;
    prev_rd  = '0;
    for (int k = 0; k < count; k++)
    begin
      rnd = $random(seed);
      opv = rnd[3:0] % 4'd10;
      rs1 = rnd[11:8];
      rs2 = rnd[15:12];
      // No reader right behind a multiply
      if (prev_mul && prev_rd != '0 && rs1 == prev_rd)
        rs1 = rs1 ^ 4'd1;
      if (prev_mul && prev_rd != '0 && rs2 == prev_rd)
        rs2 = rs2 ^ 4'd1;
      drive_slot(rnd[19:16] != 4'd0, calc_op_e'(opv), rnd[7:4], rs1, rs2, $random(seed),
                 rnd[24:20] == 5'd0);
      prev_mul = (rnd[19:16] != 4'd0) && (calc_op_e'(opv) == OP_MUL);
      prev_rd  = rnd[7:4];
    end
  endtask

  // Compare a quarter period after the edge
  always @(posedge clk)
  begin
    #(CLK_PERIOD / 4);
    if (arst_n && wb_v)
    begin
      assert (exp_addr_q.size() > 0)
      else
      begin
        errors++;
        $display("Unexpected writeback to register %0d with nothing outstanding", wb_addr);
      end
      if (exp_addr_q.size() > 0)
      begin
        exp_addr = exp_addr_q.pop_front();
        exp_data = exp_data_q.pop_front();
        assert (wb_addr == exp_addr)
        else
        begin
          errors++;
          $display("Mismatch wb_addr_o: got 0x%h expected 0x%h", wb_addr, exp_addr);
        end
        assert (wb_data == exp_data)
        else
        begin
          errors++;
          $display("Mismatch wb_data_o: got 0x%08h expected 0x%08h", wb_data, exp_data);
        end
      end
    end
  end

  initial
  begin
    #((NUM_DISPATCH + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    dispatch_v = 1'b0;
    op         = OP_NOP;
    rd_addr    = '0;
    rs1_addr   = '0;
    rs2_addr   = '0;
    imm        = '0;
    flush      = 1'b0;
    for (int i = 0; i < REG_NUM; i++)
      arch[i] = '0;
    @(posedge arst_n);
    // Seed registers, then each ALU op back to back
    for (int i = 1; i <= 8; i++)
      issue(OP_ADDI, reg_addr_t'(i), '0, '0, data_t'(i) * 32'h0123_4567 + 32'h89);
    issue(OP_ADD, 4'd9, 4'd1, 4'd2, '0);
    issue(OP_SUB, 4'd10, 4'd3, 4'd4, '0);
    issue(OP_AND, 4'd11, 4'd5, 4'd6, '0);
    issue(OP_OR, 4'd12, 4'd7, 4'd8, '0);
    issue(OP_XOR, 4'd13, 4'd1, 4'd8, '0);
    issue(OP_SLL, 4'd14, 4'd2, 4'd3, '0);
    issue(OP_SRL, 4'd15, 4'd4, 4'd5, '0);
    // Consumers at distance 1 to 4, producer value changes each round
    for (int d = 1; d <= 4; d++)
    begin
      issue(OP_ADD, 4'd2, 4'd2, 4'd3, '0);
      for (int f = 1; f < d; f++)
        issue(OP_ADDI, 4'd7, 4'd7, '0, data_t'(d));
      issue(OP_XOR, 4'd4, 4'd2, 4'd1, '0);
    end
    // Multiply and its consumers two or more slots later
    issue(OP_MUL, 4'd5, 4'd1, 4'd2, '0);
    issue(OP_ADDI, 4'd9, 4'd9, '0, 32'h5);
    issue(OP_ADD, 4'd6, 4'd5, 4'd5, '0);
    issue(OP_MUL, 4'd7, 4'd6, 4'd6, '0);
    issue(OP_OR, 4'd10, 4'd1, 4'd2, '0);
    issue(OP_AND, 4'd11, 4'd3, 4'd4, '0);
    issue(OP_SUB, 4'd8, 4'd7, 4'd1, '0);
    // x0 and NOP give no writeback
    issue(OP_ADDI, 4'd0, 4'd0, '0, 32'h5);
    issue(OP_ADD, 4'd0, 4'd1, 4'd2, '0);
    issue(OP_NOP, 4'd3, 4'd1, 4'd2, '0);
    issue(OP_ADD, 4'd9, 4'd0, 4'd0, '0);
    // Flush on the fourth write
    issue(OP_ADDI, 4'd1, 4'd0, '0, 32'hAA);
    issue(OP_ADDI, 4'd2, 4'd0, '0, 32'hBB);
    issue(OP_ADDI, 4'd3, 4'd0, '0, 32'hCC);
    drive_slot(1'b1, OP_ADDI, 4'd4, 4'd0, '0, 32'hDD, 1'b1);
    issue(OP_ADD, 4'd5, 4'd1, 4'd2, '0);
    issue(OP_ADD, 4'd6, 4'd3, 4'd4, '0);
    issue(OP_ADD, 4'd7, 4'd5, 4'd6, '0);
    run_random(RAND_INSTR);
    repeat (6) drive_slot(1'b0, OP_NOP, '0, '0, '0, '0, 1'b0);
    assert (exp_addr_q.size() == 0)
    else
    begin
      errors++;
      $display("%0d expected writebacks never appeared", exp_addr_q.size());
    end
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: hdl/calc_complete.sv
// ============================================================
// Calc completion pipe
// Carries control and poison down the pipe, merges pipe
// results at fixed latency and drives forwarding and writeback
// ============================================================
`timescale 1ns/1ps

module calc_complete (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                                          flush_i,
  input  logic                                          pipe_int_v_i,
  input  logic                                          pipe_mul_v_i,
  input  logic                                          rd_w_v_i,
  input  calc_pkg::reg_addr_t                           rd_addr_i,
  input  calc_pkg::data_t                               int_data_i,
  input  calc_pkg::data_t                               mul_data_i,
  output logic [calc_pkg::FWD_DEPTH-1:0]                fwd_v_o,
  output calc_pkg::reg_addr_t [calc_pkg::FWD_DEPTH-1:0] fwd_addr_o,
  output calc_pkg::data_t [calc_pkg::FWD_DEPTH-1:0]     fwd_data_o,
  output logic                                          wb_v_o,
  output calc_pkg::reg_addr_t                           wb_addr_o,
  output calc_pkg::data_t                               wb_data_o
);

  import calc_pkg::*;

  // Control stage 0 is the reservation stage
  logic [COMP_STAGES-1:0]    int_v_r;
  logic [COMP_STAGES-1:0]    mul_v_r;
  logic [COMP_STAGES:0]      w_v_r;
  logic [COMP_STAGES:0]      poison_r;
  logic [COMP_STAGES:0]      poison_n;
  reg_addr_t [COMP_STAGES:0] rd_r;
  data_t [COMP_STAGES-1:0]   comp_n;
  data_t [COMP_STAGES-1:0]   comp_r;

  // Flush poisons the new entry and everything not yet written back
  always_comb
  begin
    poison_n[0] = flush_i;
    for (int i = 1; i <= COMP_STAGES; i++)
      poison_n[i] = poison_r[i-1] | flush_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      int_v_r  <= '0;
      mul_v_r  <= '0;
      w_v_r    <= '0;
      poison_r <= '0;
    end
    else
    begin
      int_v_r  <= {int_v_r[COMP_STAGES-2:0], pipe_int_v_i};
      mul_v_r  <= {mul_v_r[COMP_STAGES-2:0], pipe_mul_v_i};
      w_v_r    <= {w_v_r[COMP_STAGES-1:0], rd_w_v_i};
      poison_r <= poison_n;
    end
  end

  // Results merge in at their pipe's latency, else older data moves on
  always_comb
  begin
    comp_n[0] = int_v_r[0] ? int_data_i : '0;
    comp_n[1] = mul_v_r[1] ? mul_data_i : comp_r[0];
    for (int i = 2; i < COMP_STAGES; i++)
      comp_n[i] = comp_r[i-1];
  end

  always_ff @(posedge clk_i)
  begin
    rd_r   <= {rd_r[COMP_STAGES-1:0], rd_addr_i};
    comp_r <= comp_n;
  end

  // Slice i sees stage i next-state, the multiply is not ready in slice 0
  always_comb
  begin
    for (int i = 0; i < COMP_STAGES; i++)
    begin
      fwd_v_o[i]    = w_v_r[i] & ~poison_n[i+1]
                      & (int_v_r[i] | ((i != 0) & mul_v_r[i]));
      fwd_addr_o[i] = rd_r[i];
      fwd_data_o[i] = comp_n[i];
    end
    fwd_v_o[COMP_STAGES]    = wb_v_o;
    fwd_addr_o[COMP_STAGES] = wb_addr_o;
    fwd_data_o[COMP_STAGES] = wb_data_o;
  end

  assign wb_v_o    = w_v_r[COMP_STAGES] & ~poison_r[COMP_STAGES];
  assign wb_addr_o = rd_r[COMP_STAGES];
  assign wb_data_o = comp_r[COMP_STAGES-1];

endmodule

// File: hdl/calc_decode.sv
// ============================================================
// Calc decode
// Sorts a dispatched opcode into a pipe, flags immediate use
// and raises the register write enable
// ============================================================
`timescale 1ns/1ps

module calc_decode (
  input  logic                dispatch_v_i,
  input  calc_pkg::calc_op_e  op_i,
  input  calc_pkg::reg_addr_t rd_addr_i,
  output logic                pipe_int_v_o,
  output logic                pipe_mul_v_o,
  output logic                use_imm_o,
  output logic                rd_w_v_o
);

  import calc_pkg::*;

  logic int_sel;
  logic mul_sel;

  always_comb
  begin
    int_sel   = 1'b0;
    mul_sel   = 1'b0;
    use_imm_o = 1'b0;
    case (op_i)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL:
        int_sel = 1'b1;
      OP_ADDI:
      begin
        int_sel   = 1'b1;
        use_imm_o = 1'b1;
      end
      OP_MUL:
        mul_sel = 1'b1;
      // NOP and unused codes go nowhere
      default:
        int_sel = 1'b0;
    endcase
  end

  assign pipe_int_v_o = dispatch_v_i & int_sel;
  assign pipe_mul_v_o = dispatch_v_i & mul_sel;

  // x0 is never a real destination
  assign rd_w_v_o = (pipe_int_v_o | pipe_mul_v_o) & (rd_addr_i != '0);

endmodule

// File: hdl/calc_execute.sv
// ============================================================
// Calc execute
// Single-cycle integer ALU and a two-stage multiplier
// ============================================================
`timescale 1ns/1ps

module calc_execute (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  calc_pkg::calc_op_e op_i,
  input  calc_pkg::data_t    rs1_i,
  input  calc_pkg::data_t    rs2_i,
  output calc_pkg::data_t    int_data_o,
  output calc_pkg::data_t    mul_data_o
);

  import calc_pkg::*;

  logic  mul_v_r;
  data_t mul_a_r;
  data_t mul_b_r;
  data_t product;

  // Integer pipe, result in the cycle after reservation
  always_comb
  begin
    case (op_i)
      OP_ADD, OP_ADDI: int_data_o = rs1_i + rs2_i;
      OP_SUB:          int_data_o = rs1_i - rs2_i;
      OP_AND:          int_data_o = rs1_i & rs2_i;
      OP_OR:           int_data_o = rs1_i | rs2_i;
      OP_XOR:          int_data_o = rs1_i ^ rs2_i;
      // Shift amount from the low 5 bits
      OP_SLL:          int_data_o = rs1_i << rs2_i[4:0];
      OP_SRL:          int_data_o = rs1_i >> rs2_i[4:0];
      default:         int_data_o = '0;
    endcase
  end

  // Multiply stage 1 captures operands
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      mul_v_r <= 1'b0;
    else
      mul_v_r <= (op_i == OP_MUL);
  end

  always_ff @(posedge clk_i)
  begin
    if (op_i == OP_MUL)
    begin
      mul_a_r <= rs1_i;
      mul_b_r <= rs2_i;
    end
  end

  // Low word of the product only
  assign product    = mul_a_r * mul_b_r;
  assign mul_data_o = mul_v_r ? product : '0;

endmodule

// File: hdl/calc_operand.sv
// ============================================================
// Calc operand read
// Integer register file, forwarding from in-flight stages
// and the reservation registers feeding execute
// ============================================================
`timescale 1ns/1ps

module calc_operand (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  calc_pkg::calc_op_e                           op_i,
  input  calc_pkg::reg_addr_t                          rs1_addr_i,
  input  calc_pkg::reg_addr_t                          rs2_addr_i,
  input  calc_pkg::data_t                              imm_i,
  input  logic                                         use_imm_i,
  input  logic [calc_pkg::FWD_DEPTH-1:0]               fwd_v_i,
  input  calc_pkg::reg_addr_t [calc_pkg::FWD_DEPTH-1:0] fwd_addr_i,
  input  calc_pkg::data_t [calc_pkg::FWD_DEPTH-1:0]     fwd_data_i,
  input  logic                                         wb_v_i,
  input  calc_pkg::reg_addr_t                          wb_addr_i,
  input  calc_pkg::data_t                              wb_data_i,
  output calc_pkg::calc_op_e                           op_r_o,
  output calc_pkg::data_t                              rs1_r_o,
  output calc_pkg::data_t                              rs2_r_o
);

  import calc_pkg::*;

  data_t regfile_r [REG_NUM];
  data_t rf_rs1;
  data_t rf_rs2;
  data_t byp_rs1;
  data_t byp_rs2;
  data_t opnd2;

  // Register file, x0 stays zero
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < REG_NUM; i++)
        regfile_r[i] <= '0;
    end
    else if (wb_v_i && (wb_addr_i != '0))
      regfile_r[wb_addr_i] <= wb_data_i;
  end

  assign rf_rs1 = (rs1_addr_i == '0) ? '0 : regfile_r[rs1_addr_i];
  assign rf_rs2 = (rs2_addr_i == '0) ? '0 : regfile_r[rs2_addr_i];

  // Walk oldest to youngest so slice 0 wins
  always_comb
  begin
    byp_rs1 = rf_rs1;
    byp_rs2 = rf_rs2;
    for (int i = FWD_DEPTH - 1; i >= 0; i--)
    begin
      if (fwd_v_i[i] && (fwd_addr_i[i] == rs1_addr_i) && (rs1_addr_i != '0))
        byp_rs1 = fwd_data_i[i];
      if (fwd_v_i[i] && (fwd_addr_i[i] == rs2_addr_i) && (rs2_addr_i != '0))
        byp_rs2 = fwd_data_i[i];
    end
  end

  assign opnd2 = use_imm_i ? imm_i : byp_rs2;

  // Reservation stage
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      op_r_o <= OP_NOP;
    else
      op_r_o <= op_i;
  end

  always_ff @(posedge clk_i)
  begin
    rs1_r_o <= byp_rs1;
    rs2_r_o <= opnd2;
  end

endmodule

// File: hdl/calc_top.sv
// ============================================================
// Calc back end top
// Decode, operand read, execute and completion pipe
// ============================================================
`timescale 1ns/1ps

module calc_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                dispatch_v_i,
  input  calc_pkg::calc_op_e  op_i,
  input  calc_pkg::reg_addr_t rd_addr_i,
  input  calc_pkg::reg_addr_t rs1_addr_i,
  input  calc_pkg::reg_addr_t rs2_addr_i,
  input  calc_pkg::data_t     imm_i,
  input  logic                flush_i,
  output logic                wb_v_o,
  output calc_pkg::reg_addr_t wb_addr_o,
  output calc_pkg::data_t     wb_data_o
);

  import calc_pkg::*;

  logic                      pipe_int_v;
  logic                      pipe_mul_v;
  logic                      use_imm;
  logic                      rd_w_v;
  calc_op_e                  op_r;
  data_t                     rs1_r;
  data_t                     rs2_r;
  data_t                     int_data;
  data_t                     mul_data;
  logic [FWD_DEPTH-1:0]      fwd_v;
  reg_addr_t [FWD_DEPTH-1:0] fwd_addr;
  data_t [FWD_DEPTH-1:0]     fwd_data;

  calc_decode u_decode (
    .dispatch_v_i (dispatch_v_i),
    .op_i         (op_i),
    .rd_addr_i    (rd_addr_i),
    .pipe_int_v_o (pipe_int_v),
    .pipe_mul_v_o (pipe_mul_v),
    .use_imm_o    (use_imm),
    .rd_w_v_o     (rd_w_v)
  );

  calc_operand u_operand (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .op_i       (op_i),
    .rs1_addr_i (rs1_addr_i),
    .rs2_addr_i (rs2_addr_i),
    .imm_i      (imm_i),
    .use_imm_i  (use_imm),
    .fwd_v_i    (fwd_v),
    .fwd_addr_i (fwd_addr),
    .fwd_data_i (fwd_data),
    .wb_v_i     (wb_v_o),
    .wb_addr_i  (wb_addr_o),
    .wb_data_i  (wb_data_o),
    .op_r_o     (op_r),
    .rs1_r_o    (rs1_r),
    .rs2_r_o    (rs2_r)
  );

  calc_execute u_execute (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .op_i       (op_r),
    .rs1_i      (rs1_r),
    .rs2_i      (rs2_r),
    .int_data_o (int_data),
    .mul_data_o (mul_data)
  );

  calc_complete u_complete (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .pipe_int_v_i (pipe_int_v),
    .pipe_mul_v_i (pipe_mul_v),
    .rd_w_v_i     (rd_w_v),
    .rd_addr_i    (rd_addr_i),
    .int_data_i   (int_data),
    .mul_data_i   (mul_data),
    .fwd_v_o      (fwd_v),
    .fwd_addr_o   (fwd_addr),
    .fwd_data_o   (fwd_data),
    .wb_v_o       (wb_v_o),
    .wb_addr_o    (wb_addr_o),
    .wb_data_o    (wb_data_o)
  );

endmodule
